//--- rtl/serial_isa_pkg.sv
package serial_isa_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_addr_t;

   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_JAL    = 7'b1101111,
      OPC_BRANCH = 7'b1100011,
      OPC_STORE  = 7'b0100011
   } opcode_e;

   // R and I formats, also used for U and J immediates
   typedef struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      opcode_e    opcode;
   } i_view_t;

   // S and B formats
   typedef struct packed {
      logic [6:0] imm_hi;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      opcode_e    opcode;
   } s_view_t;

   typedef union packed {
      i_view_t i_view;
      s_view_t s_view;
   } insn_u;

endpackage

//--- rtl/serial_core_pkg.sv
package serial_core_pkg;

   // Boolean and add operations of the serial ALU
   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_AND = 2'd1,
      ALU_OR  = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_e;

   // Writeback source for the rd bit
   typedef enum logic [1:0] {
      RD_ALU  = 2'd0,
      RD_IMM  = 2'd1,
      RD_LINK = 2'd2
   } rd_sel_e;

   // Bit position during the serial phase
   typedef logic [4:0] bit_cnt_t;

endpackage

//--- rtl/serial_state.sv
module serial_state
   import serial_core_pkg::*;
(
   input  logic     clk,
   input  logic     i_arst_n,
   input  logic     i_ibus_ack,
   input  logic     i_dbus_ack,
   input  logic     i_store,
   output logic     o_ibus_cyc,
   output logic     o_dbus_cyc,
   output logic     o_cnt_en,
   output bit_cnt_t o_cnt,
   output logic     o_cnt_done,
   output logic     o_fetch_done,
   output logic     o_pc_en
);

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_SERIAL,
      ST_STORE,
      ST_UPDATE
   } state_e;

   state_e   state;
   bit_cnt_t cnt;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= ST_FETCH;
         cnt   <= '0;
      end else begin
         case (state)
            ST_FETCH: begin
               if (i_ibus_ack)
                  state <= ST_SERIAL;
            end
            ST_SERIAL: begin
               // Wraps back to 0 after bit 31
               cnt <= cnt + 5'd1;
               if (o_cnt_done)
                  state <= i_store ? ST_STORE : ST_UPDATE;
            end
            ST_STORE: begin
               if (i_dbus_ack)
                  state <= ST_UPDATE;
            end
            default: state <= ST_FETCH;
         endcase
      end
   end

   assign o_ibus_cyc   = (state == ST_FETCH);
   assign o_fetch_done = o_ibus_cyc & i_ibus_ack;
   assign o_cnt_en     = (state == ST_SERIAL);
   assign o_cnt        = cnt;
   assign o_cnt_done   = o_cnt_en & (cnt == 5'd31);
   assign o_dbus_cyc   = (state == ST_STORE);
   assign o_pc_en      = (state == ST_UPDATE);

endmodule

//--- rtl/serial_decode.sv
module serial_decode
   import serial_isa_pkg::*;
   import serial_core_pkg::*;
(
   input  logic      clk,
   input  logic      i_arst_n,
   input  logic      i_fetch_done,
   input  word_t     i_insn,
   input  bit_cnt_t  i_cnt,
   output reg_addr_t o_rs1_addr,
   output reg_addr_t o_rs2_addr,
   output reg_addr_t o_rd_addr,
   output logic      o_rd_en,
   output alu_op_e   o_alu_op,
   output logic      o_sub,
   output logic      o_op_b_imm,
   output rd_sel_e   o_rd_sel,
   output logic      o_imm_bit,
   output word_t     o_imm,
   output logic      o_branch,
   output logic      o_branch_ne,
   output logic      o_jal,
   output logic      o_store
);

   insn_u insn;
   logic  is_op, is_op_imm, is_lui, is_jal, is_branch, is_store;
   word_t i_imm, s_imm, b_imm, u_imm, j_imm;

   // Cleared to an all-zero word, which executes as a no-op
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n)
         insn <= '0;
      else if (i_fetch_done)
         insn <= i_insn;
   end

   assign is_op     = (insn.i_view.opcode == OPC_OP);
   assign is_op_imm = (insn.i_view.opcode == OPC_OP_IMM);
   assign is_lui    = (insn.i_view.opcode == OPC_LUI);
   assign is_jal    = (insn.i_view.opcode == OPC_JAL);
   assign is_branch = (insn.s_view.opcode == OPC_BRANCH);
   assign is_store  = (insn.s_view.opcode == OPC_STORE);

   assign o_rs1_addr = insn.i_view.rs1;
   assign o_rs2_addr = insn.s_view.rs2;
   assign o_rd_addr  = insn.i_view.rd;
   assign o_rd_en    = (is_op | is_op_imm | is_lui | is_jal) & (insn.i_view.rd != 5'd0);

   always_comb begin
      o_alu_op = ALU_ADD;
      if (is_op | is_op_imm) begin
         case (insn.i_view.funct3)
            3'b111:  o_alu_op = ALU_AND;
            3'b110:  o_alu_op = ALU_OR;
            3'b100:  o_alu_op = ALU_XOR;
            default: o_alu_op = ALU_ADD;
         endcase
      end
   end

   assign o_sub      = is_op & (insn.i_view.funct3 == 3'b000) & insn.i_view.funct7[5];
   assign o_op_b_imm = is_op_imm | is_store;
   assign o_rd_sel   = is_lui ? RD_IMM : (is_jal ? RD_LINK : RD_ALU);

   // Immediates per format, picked from the matching view
   assign i_imm = {{20{insn.i_view.funct7[6]}}, insn.i_view.funct7, insn.i_view.rs2};
   assign s_imm = {{20{insn.s_view.imm_hi[6]}}, insn.s_view.imm_hi, insn.s_view.imm_lo};
   assign b_imm = {{20{insn.s_view.imm_hi[6]}}, insn.s_view.imm_lo[0],
                   insn.s_view.imm_hi[5:0], insn.s_view.imm_lo[4:1], 1'b0};
   assign u_imm = {insn.i_view.funct7, insn.i_view.rs2, insn.i_view.rs1,
                   insn.i_view.funct3, 12'd0};
   assign j_imm = {{12{insn.i_view.funct7[6]}}, insn.i_view.rs1, insn.i_view.funct3,
                   insn.i_view.rs2[0], insn.i_view.funct7[5:0], insn.i_view.rs2[4:1], 1'b0};

   assign o_imm = is_store  ? s_imm :
                  is_branch ? b_imm :
                  is_lui    ? u_imm :
                  is_jal    ? j_imm : i_imm;

   assign o_imm_bit = o_imm[i_cnt];

   // Only BEQ and BNE among the branch encodings
   assign o_branch    = is_branch & (insn.s_view.funct3[2:1] == 2'b00);
   assign o_branch_ne = insn.s_view.funct3[0];
   assign o_jal       = is_jal;
   assign o_store     = is_store & (insn.s_view.funct3 == 3'b010);

endmodule

//--- rtl/serial_alu.sv
module serial_alu
   import serial_core_pkg::*;
(
   input  logic     clk,
   input  logic     i_arst_n,
   input  logic     i_cnt_en,
   input  bit_cnt_t i_cnt,
   input  logic     i_rs1,
   input  logic     i_rs2,
   input  logic     i_imm_bit,
   input  logic     i_op_b_imm,
   input  alu_op_e  i_alu_op,
   input  logic     i_sub,
   output logic     o_sum,
   output logic     o_eq
);

   logic op_b, b_in, carry, carry_in, add_bit, eq_in;

   assign op_b     = i_op_b_imm ? i_imm_bit : i_rs2;
   assign b_in     = op_b ^ i_sub;
   // Carry in of 1 completes the two's complement for subtraction
   assign carry_in = (i_cnt == 5'd0) ? i_sub : carry;
   assign add_bit  = i_rs1 ^ b_in ^ carry_in;
   assign eq_in    = (i_cnt == 5'd0) ? 1'b1 : o_eq;

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         carry <= 1'b0;
         o_eq  <= 1'b0;
      end else if (i_cnt_en) begin
         carry <= (i_rs1 & b_in) | (i_rs1 & carry_in) | (b_in & carry_in);
         o_eq  <= eq_in & ~(i_rs1 ^ op_b);
      end
   end

   always_comb begin
      case (i_alu_op)
         ALU_AND: o_sum = i_rs1 & op_b;
         ALU_OR:  o_sum = i_rs1 | op_b;
         ALU_XOR: o_sum = i_rs1 ^ op_b;
         default: o_sum = add_bit;
      endcase
   end

endmodule

//--- rtl/serial_regfile.sv
module serial_regfile
   import serial_isa_pkg::*;
   import serial_core_pkg::*;
(
   input  logic      clk,
   input  logic      i_arst_n,
   input  logic      i_cnt_en,
   input  bit_cnt_t  i_cnt,
   input  reg_addr_t i_rs1_addr,
   input  reg_addr_t i_rs2_addr,
   input  reg_addr_t i_rd_addr,
   input  logic      i_rd_en,
   input  logic      i_rd,
   output logic      o_rs1,
   output logic      o_rs2
);

   word_t regs [1:31];

   // Write of bit cnt lands after its read, so rd may equal rs1 or rs2
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end else if (i_cnt_en && i_rd_en && (i_rd_addr != 5'd0)) begin
         regs[i_rd_addr][i_cnt] <= i_rd;
      end
   end

   // x0 reads as zero
   assign o_rs1 = (i_rs1_addr == 5'd0) ? 1'b0 : regs[i_rs1_addr][i_cnt];
   assign o_rs2 = (i_rs2_addr == 5'd0) ? 1'b0 : regs[i_rs2_addr][i_cnt];

endmodule

//--- rtl/serial_ctrl.sv
module serial_ctrl
   import serial_isa_pkg::*;
   import serial_core_pkg::*;
#(
   parameter word_t RESET_PC = '0
) (
   input  logic     clk,
   input  logic     i_arst_n,
   input  logic     i_pc_en,
   input  bit_cnt_t i_cnt,
   input  word_t    i_imm,
   input  logic     i_jal,
   input  logic     i_branch,
   input  logic     i_branch_ne,
   input  logic     i_eq,
   output word_t    o_ibus_adr,
   output logic     o_link
);

   word_t pc;
   word_t pc_plus4;
   word_t pc_target;
   logic  take;

   assign pc_plus4  = pc + 32'd4;
   assign pc_target = pc + i_imm;
   // BNE inverts the sense of the compare
   assign take      = i_jal | (i_branch & (i_eq ^ i_branch_ne));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n)
         pc <= RESET_PC;
      else if (i_pc_en)
         pc <= take ? pc_target : pc_plus4;
   end

   assign o_ibus_adr = pc;
   assign o_link     = pc_plus4[i_cnt];

endmodule

//--- rtl/serial_store.sv
module serial_store
   import serial_isa_pkg::*;
(
   input  logic  clk,
   input  logic  i_arst_n,
   input  logic  i_cnt_en,
   input  logic  i_store,
   input  logic  i_sum,
   input  logic  i_rs2,
   output word_t o_dbus_adr,
   output word_t o_dbus_dat
);

   word_t adr_q;
   word_t dat_q;

   // LSB arrives first, so shift in from the top
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         adr_q <= '0;
         dat_q <= '0;
      end else if (i_cnt_en && i_store) begin
         adr_q <= {i_sum, adr_q[31:1]};
         dat_q <= {i_rs2, dat_q[31:1]};
      end
   end

   // Word accesses only
   assign o_dbus_adr = {adr_q[31:2], 2'b00};
   assign o_dbus_dat = dat_q;

endmodule

//--- rtl/serial_core.sv
module serial_core
   import serial_isa_pkg::*;
   import serial_core_pkg::*;
#(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  i_arst_n,
   output word_t o_ibus_adr,
   output logic  o_ibus_cyc,
   input  word_t i_ibus_rdt,
   input  logic  i_ibus_ack,
   output word_t o_dbus_adr,
   output word_t o_dbus_dat,
   output logic  o_dbus_cyc,
   input  logic  i_dbus_ack
);

   bit_cnt_t  cnt;
   logic      cnt_en, fetch_done, pc_en;
   reg_addr_t rs1_addr, rs2_addr, rd_addr;
   logic      rd_en, sub, op_b_imm, imm_bit;
   alu_op_e   alu_op;
   rd_sel_e   rd_sel;
   word_t     imm;
   logic      branch, branch_ne, jal, store;
   logic      rs1, rs2, sum, eq, link, rd;

   serial_state u_state (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_ibus_ack   (i_ibus_ack),
      .i_dbus_ack   (i_dbus_ack),
      .i_store      (store),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_dbus_cyc   (o_dbus_cyc),
      .o_cnt_en     (cnt_en),
      .o_cnt        (cnt),
      .o_cnt_done   (),
      .o_fetch_done (fetch_done),
      .o_pc_en      (pc_en)
   );

   serial_decode u_decode (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_fetch_done (fetch_done),
      .i_insn       (i_ibus_rdt),
      .i_cnt        (cnt),
      .o_rs1_addr   (rs1_addr),
      .o_rs2_addr   (rs2_addr),
      .o_rd_addr    (rd_addr),
      .o_rd_en      (rd_en),
      .o_alu_op     (alu_op),
      .o_sub        (sub),
      .o_op_b_imm   (op_b_imm),
      .o_rd_sel     (rd_sel),
      .o_imm_bit    (imm_bit),
      .o_imm        (imm),
      .o_branch     (branch),
      .o_branch_ne  (branch_ne),
      .o_jal        (jal),
      .o_store      (store)
   );

   serial_alu u_alu (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .i_imm_bit  (imm_bit),
      .i_op_b_imm (op_b_imm),
      .i_alu_op   (alu_op),
      .i_sub      (sub),
      .o_sum      (sum),
      .o_eq       (eq)
   );

   serial_regfile u_regfile (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt_en   (cnt_en),
      .i_cnt      (cnt),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_rd_en    (rd_en),
      .i_rd       (rd),
      .o_rs1      (rs1),
      .o_rs2      (rs2)
   );

   serial_ctrl #(
      .RESET_PC (RESET_PC)
   ) u_ctrl (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_pc_en     (pc_en),
      .i_cnt       (cnt),
      .i_imm       (imm),
      .i_jal       (jal),
      .i_branch    (branch),
      .i_branch_ne (branch_ne),
      .i_eq        (eq),
      .o_ibus_adr  (o_ibus_adr),
      .o_link      (link)
   );

   serial_store u_store (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt_en   (cnt_en),
      .i_store    (store),
      .i_sum      (sum),
      .i_rs2      (rs2),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

   // Writeback bit source
   always_comb begin
      case (rd_sel)
         RD_IMM:  rd = imm_bit;
         RD_LINK: rd = link;
         default: rd = sum;
      endcase
   end

endmodule

//--- tests/serial_core_assert.sv
module serial_core_assert
   import serial_isa_pkg::*;
(
   input logic  clk,
   input logic  i_arst_n,
   input logic  i_ibus_cyc,
   input logic  i_ibus_ack,
   input logic  i_dbus_cyc,
   input logic  i_dbus_ack,
   input word_t i_dbus_adr
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned violations = 0;

   a_one_bus: assert property (@(posedge clk) disable iff (!i_arst_n)
      !(i_ibus_cyc && i_dbus_cyc))
      else begin
         violations++;
         $error("Instruction and data bus cycles overlap");
      end

   a_ibus_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_ibus_cyc && !i_ibus_ack |=> i_ibus_cyc)
      else begin
         violations++;
         $error("Instruction bus cycle dropped before its ack");
      end

   a_ibus_end: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_ibus_cyc && i_ibus_ack |=> !i_ibus_cyc)
      else begin
         violations++;
         $error("Instruction bus cycle still high after its ack");
      end

   a_dbus_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_dbus_cyc && !i_dbus_ack |=> i_dbus_cyc)
      else begin
         violations++;
         $error("Data bus cycle dropped before its ack");
      end

   a_dbus_end: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_dbus_cyc && i_dbus_ack |=> !i_dbus_cyc)
      else begin
         violations++;
         $error("Data bus cycle still high after its ack");
      end

   a_dbus_align: assert property (@(posedge clk) disable iff (!i_arst_n)
      i_dbus_cyc |-> i_dbus_adr[1:0] == 2'b00)
      else begin
         violations++;
         $error("Unaligned data bus address %h", i_dbus_adr);
      end

endmodule

//--- tests/tb_serial_core.sv
module tb_serial_core
   import serial_isa_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   logic  clk = 1'b0;
   logic  arst_n;
   word_t ibus_adr;
   logic  ibus_cyc;
   word_t ibus_rdt;
   logic  ibus_ack;
   word_t dbus_adr;
   word_t dbus_dat;
   logic  dbus_cyc;
   logic  dbus_ack;

   word_t imem [0:1023];
   int    n_prog = 0;

   // Expected stores in program order
   string exp_name [$];
   word_t exp_adr [$];
   word_t exp_dat [$];
   int    n_exp = 0;
   int    exp_idx = 0;
   int    pass_count = 0;
   int    fail_count = 0;
   bit    loaded = 1'b0;

   // The program ends with a jump to itself at its last word
   word_t halt_adr = '0;
   int    halt_count = 0;

   logic [15:0] lfsr = 16'd18760;
   bit          ibus_busy = 1'b0;
   int          ibus_wait = 0;
   bit          dbus_busy = 1'b0;
   int          dbus_wait = 0;

   serial_core #(
      .RESET_PC (32'h0000_0000)
   ) i_dut (
      .clk        (clk),
      .i_arst_n   (arst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_ack (dbus_ack)
   );

   bind serial_core serial_core_assert u_assert (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_cyc (o_ibus_cyc),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack),
      .i_dbus_adr (o_dbus_adr)
   );

   always #20 clk = ~clk;

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_delay(output int d);
      d = 0;
      for (int b = 0; b < 2; b++) begin
         lfsr = lfsr_next(lfsr);
         d = (d << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic load_tests(output bit ok);
      int    fd;
      int    code;
      string tag;
      string line;
      string name;
      word_t a;
      word_t d;
      ok = 1'b0;
      // Unused words get an opcode ending in 00, which runs as a no-op
      for (int i = 0; i < 1024; i++)
         imem[i] = word_t'(i) * 32'h0001_0004;
      fd = $fopen("tests/serial_core_tests.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code == 1) begin
               if (tag == "P") begin
                  code = $fscanf(fd, "%h %h", a, d);
                  imem[a[11:2]] = d;
                  halt_adr = a;
                  n_prog++;
               end else if (tag == "S") begin
                  code = $fscanf(fd, "%s %h %h", name, a, d);
                  exp_name.push_back(name);
                  exp_adr.push_back(a);
                  exp_dat.push_back(d);
               end else begin
                  code = $fgets(line, fd);
               end
            end
         end
         $fclose(fd);
         n_exp = exp_name.size();
      end
   endtask

   task automatic check_addr(input string name, input word_t exp, input word_t act,
                             inout bit ok);
      if (act !== exp) begin
         $display("ERR %s address: expected %h, actual %h", name, exp, act);
         ok = 1'b0;
      end
   endtask

   task automatic check_data(input string name, input word_t exp, input word_t act,
                             inout bit ok);
      if (act !== exp) begin
         $display("ERR %s data: expected %h, actual %h", name, exp, act);
         ok = 1'b0;
      end
   endtask

   task automatic check_store(input word_t adr, input word_t dat);
      bit    ok;
      string name;
      if (exp_idx >= n_exp) begin
         $display("Store to %h with data %h arrived after the last expected store", adr, dat);
         fail_count++;
      end else begin
         name = exp_name[exp_idx];
         ok   = 1'b1;
         check_addr(name, exp_adr[exp_idx], adr, ok);
         check_data(name, exp_dat[exp_idx], dat, ok);
         if (ok) begin
            pass_count++;
            $display("%-10s ok", name);
         end else begin
            fail_count++;
            $display("%-10s failed", name);
         end
         exp_idx++;
      end
   endtask

   // Instruction memory, 0 to 3 idle cycles before each ack
   always @(posedge clk) begin
      if (ibus_ack) begin
         ibus_ack <= 1'b0;
      end else if (arst_n && ibus_cyc) begin
         if (!ibus_busy) begin
            ibus_busy = 1'b1;
            random_delay(ibus_wait);
         end
         if (ibus_wait == 0) begin
            ibus_busy = 1'b0;
            ibus_rdt <= imem[ibus_adr[11:2]];
            ibus_ack <= 1'b1;
            if (ibus_adr == halt_adr)
               halt_count++;
         end else begin
            ibus_wait--;
         end
      end
   end

   // Data memory, checks each write as it is acked
   always @(posedge clk) begin
      if (dbus_ack) begin
         dbus_ack <= 1'b0;
      end else if (arst_n && dbus_cyc) begin
         if (!dbus_busy) begin
            dbus_busy = 1'b1;
            random_delay(dbus_wait);
         end
         if (dbus_wait == 0) begin
            dbus_busy = 1'b0;
            dbus_ack <= 1'b1;
            check_store(dbus_adr, dbus_dat);
         end else begin
            dbus_wait--;
         end
      end
   end

   initial begin : watchdog
      longint limit_ns;
      wait (loaded);
      limit_ns = longint'(n_prog * 4 + 8) * 45 * 40;
      #(limit_ns);
      $display("Watchdog expired after %0d ns with %0d of %0d stores seen",
               limit_ns, exp_idx, n_exp);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin : main
      bit load_ok;
      arst_n   = 1'b0;
      ibus_rdt = '0;
      ibus_ack = 1'b0;
      dbus_ack = 1'b0;
      load_tests(load_ok);
      if (!load_ok) begin
         $display("Could not open tests/serial_core_tests.txt");
         $display("*** TEST FAILED ***");
      end else begin
         loaded = 1'b1;
         repeat (16) @(posedge clk);
         arst_n <= 1'b1;
         // Second fetch of the last word means the final jump has run
         wait (halt_count >= 2);
         if (exp_idx < n_exp) begin
            $display("%0d expected stores never arrived", n_exp - exp_idx);
            fail_count += n_exp - exp_idx;
         end
         $display("Done: %0d passed, %0d failed, %0d assertion failures",
                  pass_count, fail_count, i_dut.u_assert.violations);
         if (fail_count == 0 && i_dut.u_assert.violations == 0) begin
            $display("*** TEST PASSED ***");
         end else begin
            $display("*** TEST FAILED ***");
         end
      end
      $finish;
   end

endmodule

//--- tests/serial_core_tests.txt
# P addr word           program word at a byte address
# S name addr data      expected data bus write, in program order
P 00000000 40000F93  # addi x31, x0, 0x400
P 00000004 06400093  # addi x1, x0, 100
P 00000008 FF900113  # addi x2, x0, -7
P 0000000C 002081B3  # add  x3, x1, x2
P 00000010 40110233  # sub  x4, x2, x1
P 00000014 FE2FAE23  # sw   x2, -4(x31)
P 00000018 FE3FAC23  # sw   x3, -8(x31)
P 0000001C FE4FAA23  # sw   x4, -12(x31)
P 00000020 5A300293  # addi x5, x0, 0x5a3
P 00000024 0F02F313  # andi x6, x5, 0x0f0
P 00000028 F002E393  # ori  x7, x5, -256
P 0000002C 7FF2C413  # xori x8, x5, 0x7ff
P 00000030 0022F4B3  # and  x9, x5, x2
P 00000034 00136533  # or   x10, x6, x1
P 00000038 0053C5B3  # xor  x11, x7, x5
P 0000003C FE6FA823  # sw   x6, -16(x31)
P 00000040 FE7FA623  # sw   x7, -20(x31)
P 00000044 FE8FA423  # sw   x8, -24(x31)
P 00000048 FE9FA223  # sw   x9, -28(x31)
P 0000004C FEAFA023  # sw   x10, -32(x31)
P 00000050 FCBFAE23  # sw   x11, -36(x31)
P 00000054 ABCDE637  # lui  x12, 0xabcde
P 00000058 FCCFAC23  # sw   x12, -40(x31)
P 0000005C 00508013  # addi x0, x1, 5
P 00000060 FC0FAA23  # sw   x0, -44(x31)
P 00000064 01100693  # addi x13, x0, 0x11
P 00000068 00108463  # beq  x1, x1, +8
P 0000006C 02100693  # addi x13, x0, 0x21
P 00000070 FCDFA823  # sw   x13, -48(x31)
P 00000074 01200693  # addi x13, x0, 0x12
P 00000078 00208463  # beq  x1, x2, +8
P 0000007C 02200693  # addi x13, x0, 0x22
P 00000080 FCDFA623  # sw   x13, -52(x31)
P 00000084 01300693  # addi x13, x0, 0x13
P 00000088 00209463  # bne  x1, x2, +8
P 0000008C 02300693  # addi x13, x0, 0x23
P 00000090 FCDFA423  # sw   x13, -56(x31)
P 00000094 01400693  # addi x13, x0, 0x14
P 00000098 00109463  # bne  x1, x1, +8
P 0000009C 02400693  # addi x13, x0, 0x24
P 000000A0 FCDFA223  # sw   x13, -60(x31)
P 000000A4 008007EF  # jal  x15, +8
P 000000A8 FC1FA023  # sw   x1, -64(x31), skipped by the jump
P 000000AC FAFFAE23  # sw   x15, -68(x31)
P 000000B0 801FA023  # sw   x1, -2048(x31)
P 000000B4 0000006F  # jal  x0, 0
S addi      000003FC FFFFFFF9
S add       000003F8 0000005D
S sub       000003F4 FFFFFF95
S andi      000003F0 000000A0
S ori       000003EC FFFFFFA3
S xori      000003E8 0000025C
S and       000003E4 000005A1
S or        000003E0 000000E4
S xor       000003DC FFFFFA00
S lui       000003D8 ABCDE000
S x0_write  000003D4 00000000
S beq_taken 000003D0 00000011
S beq_not   000003CC 00000022
S bne_taken 000003C8 00000013
S bne_not   000003C4 00000024
S jal_link  000003BC 000000A8
S neg_imm   FFFFFC00 00000064

//--- verilog.f
rtl/serial_isa_pkg.sv
rtl/serial_core_pkg.sv
rtl/serial_state.sv
rtl/serial_decode.sv
rtl/serial_alu.sv
rtl/serial_regfile.sv
rtl/serial_ctrl.sv
rtl/serial_store.sv
rtl/serial_core.sv
tests/serial_core_assert.sv
tests/tb_serial_core.sv

//--- Bender.yml
package:
  name: serial_core

sources:
  - rtl/serial_isa_pkg.sv
  - rtl/serial_core_pkg.sv
  - rtl/serial_state.sv
  - rtl/serial_decode.sv
  - rtl/serial_alu.sv
  - rtl/serial_regfile.sv
  - rtl/serial_ctrl.sv
  - rtl/serial_store.sv
  - rtl/serial_core.sv
  - target: test
    files:
      - tests/serial_core_assert.sv
      - tests/tb_serial_core.sv
